/* dv/tb_axi_burst_splitter.sv */
/*
  Testbench for the AXI burst splitter with random INCR and FIXED bursts.
  Bursts have len 0-7 and size 0-2; no WRAP bursts are sent.
  The downstream slave model answers in order, and address bit 12 gives SLVERR.
  The run stops at the first mismatch and is bounded by a cycle timeout.
*/
`timescale 1ns/1ps

module tb_axi_burst_splitter;
  import burst_split_pkg::*;

  localparam int          NUM_WR         = 40;
  localparam int          NUM_RD         = 40;
  localparam int          TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] LFSR_SEED      = 32'hefa2_649c;
  localparam data_t       RDATA_XOR      = 32'h5a5a_0000;

  typedef addr_t addr_list_t[$];

  logic     clk_i;
  logic     arst_n_i;
  aw_chan_t s_aw_i       = '0;
  logic     s_aw_valid_i = 1'b0;
  logic     s_aw_ready_o;
  w_chan_t  s_w_i        = '0;
  logic     s_w_valid_i  = 1'b0;
  logic     s_w_ready_o;
  b_chan_t  s_b_o;
  logic     s_b_valid_o;
  logic     s_b_ready_i  = 1'b0;
  ar_chan_t s_ar_i       = '0;
  logic     s_ar_valid_i = 1'b0;
  logic     s_ar_ready_o;
  r_chan_t  s_r_o;
  logic     s_r_valid_o;
  logic     s_r_ready_i  = 1'b0;
  aw_chan_t m_aw_o;
  logic     m_aw_valid_o;
  logic     m_aw_ready_i = 1'b0;
  w_chan_t  m_w_o;
  logic     m_w_valid_o;
  logic     m_w_ready_i  = 1'b0;
  b_chan_t  m_b_i        = '0;
  logic     m_b_valid_i  = 1'b0;
  logic     m_b_ready_o;
  ar_chan_t m_ar_o;
  logic     m_ar_valid_o;
  logic     m_ar_ready_i = 1'b0;
  r_chan_t  m_r_i        = '0;
  logic     m_r_valid_i  = 1'b0;
  logic     m_r_ready_o;

  // Stimulus and expected traffic in issue order
  aw_chan_t wr_bursts [$];
  ar_chan_t rd_bursts [$];
  w_chan_t  w_beats   [$];
  aw_chan_t exp_aw_q  [$];
  w_chan_t  exp_w_q   [$];
  b_chan_t  exp_b_q   [$];
  ar_chan_t exp_ar_q  [$];
  r_chan_t  exp_r_q   [$];
  // Slave model state
  b_chan_t  slv_b_q   [$];
  r_chan_t  slv_r_q   [$];
  int       slv_w_cnt = 0;

  logic [31:0] lfsr_q = LFSR_SEED;
  int       aw_idx      = 0;
  int       w_idx       = 0;
  int       ar_idx      = 0;
  int       b_stall     = 0;
  int       r_stall     = 0;
  int       wait_cycles = 0;
  logic     drive_en    = 1'b0;
  logic     timed_out;
  // Handshakes seen at the falling edge and acted on after the next rising edge
  logic     up_aw_fire = 1'b0;
  logic     up_w_fire  = 1'b0;
  logic     up_ar_fire = 1'b0;
  logic     dn_aw_fire = 1'b0;
  logic     dn_w_fire  = 1'b0;
  logic     dn_ar_fire = 1'b0;
  logic     dn_b_fire  = 1'b0;
  logic     dn_r_fire  = 1'b0;
  aw_chan_t dn_aw_beat;
  ar_chan_t dn_ar_beat;

  axi_burst_splitter axi_burst_splitter_i (.*);

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic aw_chan_t random_burst();
    aw_chan_t ax;
    ax.id    = id_t'(rand_bits(ID_W));
    ax.len   = len_t'(rand_bits(3));
    ax.size  = size_t'(rand_bits(2));
    if (ax.size == 3'd3) begin
      ax.size = 3'd2;
    end
    ax.burst = (rand_bits(1) != 0) ? BURST_INCR : BURST_FIXED;
    // Half start just below 0x1000 or 0x2000 so bit 12 may change inside the burst
    if (rand_bits(1) != 0) begin
      ax.addr = rand_bits(1) << 12;
      ax.addr = ax.addr | 32'h0000_0fe0 | rand_bits(5);
    end else begin
      ax.addr = rand_bits(16);
    end
    ax.addr = ax.addr & ~((addr_t'(1) << ax.size) - addr_t'(1));
    return ax;
  endfunction

  // Expected sub-addresses of one burst and its merged response
  function automatic resp_t ref_burst(input addr_t addr, input len_t len, input size_t size,
                                      input burst_t burst, output addr_list_t addrs);
    resp_t resp;
    addr_t a;
    resp  = RESP_OKAY;
    addrs = {};
    for (int i = 0; i <= int'(len); i++) begin
      a = (burst == BURST_INCR) ? addr + (addr_t'(i) << size) : addr;
      addrs.push_back(a);
      if (a[12]) begin
        resp = RESP_SLVERR;
      end
    end
    return resp;
  endfunction

  task automatic build_bursts();
    addr_list_t addrs;
    aw_chan_t   aw;
    ar_chan_t   ar;
    aw_chan_t   sub_aw;
    ar_chan_t   sub_ar;
    w_chan_t    w;
    b_chan_t    b;
    r_chan_t    r;
    for (int n = 0; n < NUM_WR; n++) begin
      aw = random_burst();
      wr_bursts.push_back(aw);
      b.id   = aw.id;
      b.resp = ref_burst(aw.addr, aw.len, aw.size, aw.burst, addrs);
      exp_b_q.push_back(b);
      sub_aw     = aw;
      sub_aw.len = '0;
      foreach (addrs[i]) begin
        sub_aw.addr = addrs[i];
        exp_aw_q.push_back(sub_aw);
        w.data = rand_bits(DATA_W);
        w.strb = strb_t'(rand_bits(STRB_W));
        w.last = (i == addrs.size() - 1);
        w_beats.push_back(w);
        w.last = 1'b1;
        exp_w_q.push_back(w);
      end
    end
    for (int n = 0; n < NUM_RD; n++) begin
      ar = ar_chan_t'(random_burst());
      rd_bursts.push_back(ar);
      void'(ref_burst(ar.addr, ar.len, ar.size, ar.burst, addrs));
      sub_ar     = ar;
      sub_ar.len = '0;
      foreach (addrs[i]) begin
        sub_ar.addr = addrs[i];
        exp_ar_q.push_back(sub_ar);
        r.id   = ar.id;
        r.data = addrs[i] ^ RDATA_XOR;
        r.resp = addrs[i][12] ? RESP_SLVERR : RESP_OKAY;
        r.last = (i == addrs.size() - 1);
        exp_r_q.push_back(r);
      end
    end
  endtask

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic logic drained();
    return exp_aw_q.size() == 0 && exp_w_q.size() == 0 && exp_ar_q.size() == 0 &&
           slv_b_q.size() == 0 && slv_r_q.size() == 0 && slv_w_cnt == 0 &&
           !m_b_valid_i && !m_r_valid_i;
  endfunction

  // --------------------------------------------------
  // Clock, reset and end of run
  // --------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  initial begin
    arst_n_i = 1'b0;
    build_bursts();
    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    // A burst is done once its B or its final R beat has gone upstream
    while ((exp_b_q.size() != 0 || exp_r_q.size() != 0) && wait_cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      wait_cycles++;
    end
    timed_out = (exp_b_q.size() != 0 || exp_r_q.size() != 0);
    if (!timed_out) begin
      repeat (16) @(posedge clk_i);
    end
    if (timed_out) begin
      fail_stop($sformatf("Timeout after %0d cycles, %0d B and %0d R responses never arrived",
                          wait_cycles, exp_b_q.size(), exp_r_q.size()));
    end else if (!drained()) begin
      fail_stop("Run ended with downstream requests or slave responses left over");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

  // --------------------------------------------------
  // Compare process sampled mid-cycle
  // --------------------------------------------------
  always @(negedge clk_i) begin
    up_aw_fire = s_aw_valid_i && s_aw_ready_o;
    up_w_fire  = s_w_valid_i && s_w_ready_o;
    up_ar_fire = s_ar_valid_i && s_ar_ready_o;
    dn_aw_fire = m_aw_valid_o && m_aw_ready_i;
    dn_w_fire  = m_w_valid_o && m_w_ready_i;
    dn_ar_fire = m_ar_valid_o && m_ar_ready_i;
    dn_b_fire  = m_b_valid_i && m_b_ready_o;
    dn_r_fire  = m_r_valid_i && m_r_ready_o;
    dn_aw_beat = m_aw_o;
    dn_ar_beat = m_ar_o;

    if (dn_aw_fire) begin
      assert (exp_aw_q.size() != 0)
        else fail_stop("Downstream AW request seen after all write bursts were split");
      assert (m_aw_o == exp_aw_q[0])
        else fail_stop($sformatf("MISMATCH at %0t: AW %h %h %0d %0d %0d, expected %h %h 0 %0d %0d",
                                 $time, m_aw_o.id, m_aw_o.addr, m_aw_o.len, m_aw_o.size,
                                 m_aw_o.burst, exp_aw_q[0].id, exp_aw_q[0].addr,
                                 exp_aw_q[0].size, exp_aw_q[0].burst));
      exp_aw_q.delete(0);
    end
    if (dn_w_fire) begin
      assert (exp_w_q.size() != 0)
        else fail_stop("Downstream W beat seen with no write data outstanding");
      assert (m_w_o == exp_w_q[0])
        else fail_stop($sformatf("MISMATCH at %0t: W data %h strb %h last %b, expected %h %h 1",
                                 $time, m_w_o.data, m_w_o.strb, m_w_o.last,
                                 exp_w_q[0].data, exp_w_q[0].strb));
      exp_w_q.delete(0);
    end
    if (dn_ar_fire) begin
      assert (exp_ar_q.size() != 0)
        else fail_stop("Downstream AR request seen after all read bursts were split");
      assert (m_ar_o == exp_ar_q[0])
        else fail_stop($sformatf("MISMATCH at %0t: AR %h %h %0d %0d %0d, expected %h %h 0 %0d %0d",
                                 $time, m_ar_o.id, m_ar_o.addr, m_ar_o.len, m_ar_o.size,
                                 m_ar_o.burst, exp_ar_q[0].id, exp_ar_q[0].addr,
                                 exp_ar_q[0].size, exp_ar_q[0].burst));
      exp_ar_q.delete(0);
    end
    if (s_b_valid_o && s_b_ready_i) begin
      assert (exp_b_q.size() != 0)
        else fail_stop("Upstream B response arrived with no write burst open");
      assert (s_b_o == exp_b_q[0])
        else fail_stop($sformatf("MISMATCH at %0t: B id %h resp %b, expected id %h resp %b",
                                 $time, s_b_o.id, s_b_o.resp, exp_b_q[0].id, exp_b_q[0].resp));
      exp_b_q.delete(0);
    end
    if (s_r_valid_o && s_r_ready_i) begin
      assert (exp_r_q.size() != 0)
        else fail_stop("Upstream R beat arrived with no read burst open");
      assert (s_r_o == exp_r_q[0])
        else fail_stop($sformatf("MISMATCH at %0t: R %h/%h/%b/%b, expected %h/%h/%b/%b",
                                 $time, s_r_o.id, s_r_o.data, s_r_o.resp, s_r_o.last,
                                 exp_r_q[0].id, exp_r_q[0].data, exp_r_q[0].resp,
                                 exp_r_q[0].last));
      exp_r_q.delete(0);
    end
  end

  // --------------------------------------------------
  // Upstream master and downstream slave drivers
  // --------------------------------------------------
  always @(posedge clk_i) begin : drive
    b_chan_t sb;
    r_chan_t sr;
    drive_en = arst_n_i;
    #1;
    if (drive_en) begin
      if (up_aw_fire) begin
        s_aw_valid_i = 1'b0;
        aw_idx++;
      end
      if (!s_aw_valid_i && aw_idx < wr_bursts.size() && rand_bits(1) != 0) begin
        s_aw_i       = wr_bursts[aw_idx];
        s_aw_valid_i = 1'b1;
      end
      if (up_w_fire) begin
        s_w_valid_i = 1'b0;
        w_idx++;
      end
      if (!s_w_valid_i && w_idx < w_beats.size() && rand_bits(2) != 0) begin
        s_w_i       = w_beats[w_idx];
        s_w_valid_i = 1'b1;
      end
      if (up_ar_fire) begin
        s_ar_valid_i = 1'b0;
        ar_idx++;
      end
      if (!s_ar_valid_i && ar_idx < rd_bursts.size() && rand_bits(1) != 0) begin
        s_ar_i       = rd_bursts[ar_idx];
        s_ar_valid_i = 1'b1;
      end

      // Upstream readies drop for stretches so the trackers fill up
      if (b_stall != 0) begin
        b_stall--;
      end else if (rand_bits(3) == 0) begin
        b_stall = int'(rand_bits(5));
      end
      s_b_ready_i = (b_stall == 0);
      if (r_stall != 0) begin
        r_stall--;
      end else if (rand_bits(3) == 0) begin
        r_stall = int'(rand_bits(5));
      end
      s_r_ready_i = (r_stall == 0);

      // Slave side answers each single-beat request once and in order
      m_aw_ready_i = (rand_bits(2) != 0);
      m_w_ready_i  = (rand_bits(2) != 0);
      m_ar_ready_i = (rand_bits(2) != 0);
      if (dn_aw_fire) begin
        sb.id   = dn_aw_beat.id;
        sb.resp = dn_aw_beat.addr[12] ? RESP_SLVERR : RESP_OKAY;
        slv_b_q.push_back(sb);
      end
      if (dn_w_fire) begin
        slv_w_cnt++;
      end
      if (dn_ar_fire) begin
        sr.id   = dn_ar_beat.id;
        sr.data = dn_ar_beat.addr ^ RDATA_XOR;
        sr.resp = dn_ar_beat.addr[12] ? RESP_SLVERR : RESP_OKAY;
        sr.last = 1'b1;
        slv_r_q.push_back(sr);
      end
      if (dn_b_fire) begin
        m_b_valid_i = 1'b0;
      end
      // B needs both the request and its data beat
      if (!m_b_valid_i && slv_b_q.size() != 0 && slv_w_cnt != 0 && rand_bits(1) != 0) begin
        m_b_i       = slv_b_q.pop_front();
        m_b_valid_i = 1'b1;
        slv_w_cnt--;
      end
      if (dn_r_fire) begin
        m_r_valid_i = 1'b0;
      end
      if (!m_r_valid_i && slv_r_q.size() != 0 && rand_bits(1) != 0) begin
        m_r_i       = slv_r_q.pop_front();
        m_r_valid_i = 1'b1;
      end
    end
  end

endmodule

/* hdl/ax_splitter.sv */
/*
  Splits one AW or AR burst into len+1 single-beat requests.
  INCR steps the address by 2^size, FIXED repeats it; WRAP is not handled.
  Single-beat requests pass through combinationally.
  A burst is only accepted while the tracker reports room.
*/
`timescale 1ns/1ps

module ax_splitter #(
  parameter type chan_t = burst_split_pkg::aw_chan_t
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Upstream address channel
  input  chan_t                 ax_i,
  input  logic                  ax_valid_i,
  output logic                  ax_ready_o,
  // Downstream address channel
  output chan_t                 ax_o,
  output logic                  ax_valid_o,
  input  logic                  ax_ready_i,
  // Tracker allocation
  output logic                  alloc_o,
  output burst_split_pkg::len_t alloc_len_o,
  input  logic                  alloc_room_i
);
  import burst_split_pkg::*;

  typedef enum logic {ST_IDLE, ST_BUSY} state_e;

  state_e state_d, state_q;
  chan_t  ax_d, ax_q;

  // Count one beat off and move to the next beat address
  function automatic chan_t next_beat(chan_t ax);
    chan_t nxt;
    nxt     = ax;
    nxt.len = ax.len - 1'b1;
    if (ax.burst == BURST_INCR) begin
      nxt.addr = ax.addr + (ADDR_W'(1) << ax.size);
    end
    return nxt;
  endfunction

  assign alloc_len_o = ax_i.len;

  always_comb begin
    state_d    = state_q;
    ax_d       = ax_q;
    ax_o       = ax_q;
    ax_o.len   = '0;
    ax_valid_o = 1'b0;
    ax_ready_o = 1'b0;
    alloc_o    = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (ax_valid_i && alloc_room_i) begin
          ax_o       = ax_i;
          ax_o.len   = '0;
          ax_valid_o = 1'b1;
          if (ax_i.len == '0) begin
            // Nothing to split, hand over only when downstream takes it
            if (ax_ready_i) begin
              ax_ready_o = 1'b1;
              alloc_o    = 1'b1;
            end
          end else begin
            // Take the burst now, first beat goes out in parallel
            ax_ready_o = 1'b1;
            alloc_o    = 1'b1;
            state_d    = ST_BUSY;
            ax_d       = ax_ready_i ? next_beat(ax_i) : ax_i;
          end
        end
      end
      ST_BUSY: begin
        ax_valid_o = 1'b1;
        if (ax_ready_i) begin
          if (ax_q.len == '0) begin
            state_d = ST_IDLE;
          end else begin
            ax_d = next_beat(ax_q);
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Burst copy, len holds the beats left after the one on offer
  always_ff @(posedge clk_i) begin
    ax_q <= ax_d;
  end

endmodule

/* hdl/axi_burst_splitter.sv */
/*
  AXI4 burst splitter: every AW/AR burst leaves as len+1 single beats.
  Downstream must return B and R in request order per direction.
  No WRAP bursts, no ATOPs, no user fields.
  Up to MAX_TXNS bursts per direction may be outstanding.
*/
`timescale 1ns/1ps

module axi_burst_splitter (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Upstream port
  input  burst_split_pkg::aw_chan_t s_aw_i,
  input  logic                      s_aw_valid_i,
  output logic                      s_aw_ready_o,
  input  burst_split_pkg::w_chan_t  s_w_i,
  input  logic                      s_w_valid_i,
  output logic                      s_w_ready_o,
  output burst_split_pkg::b_chan_t  s_b_o,
  output logic                      s_b_valid_o,
  input  logic                      s_b_ready_i,
  input  burst_split_pkg::ar_chan_t s_ar_i,
  input  logic                      s_ar_valid_i,
  output logic                      s_ar_ready_o,
  output burst_split_pkg::r_chan_t  s_r_o,
  output logic                      s_r_valid_o,
  input  logic                      s_r_ready_i,
  // Downstream port
  output burst_split_pkg::aw_chan_t m_aw_o,
  output logic                      m_aw_valid_o,
  input  logic                      m_aw_ready_i,
  output burst_split_pkg::w_chan_t  m_w_o,
  output logic                      m_w_valid_o,
  input  logic                      m_w_ready_i,
  input  burst_split_pkg::b_chan_t  m_b_i,
  input  logic                      m_b_valid_i,
  output logic                      m_b_ready_o,
  output burst_split_pkg::ar_chan_t m_ar_o,
  output logic                      m_ar_valid_o,
  input  logic                      m_ar_ready_i,
  input  burst_split_pkg::r_chan_t  m_r_i,
  input  logic                      m_r_valid_i,
  output logic                      m_r_ready_o
);
  import burst_split_pkg::*;

  logic w_alloc, w_room, w_dec, w_set_err, w_last_beat, w_err;
  len_t w_alloc_len;
  logic r_alloc, r_room, r_dec, r_last_beat;
  len_t r_alloc_len;

  // --------------------------------------------------
  // Write direction
  // --------------------------------------------------
  ax_splitter #(
    .chan_t       (aw_chan_t)
  ) aw_splitter_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .ax_i         (s_aw_i),
    .ax_valid_i   (s_aw_valid_i),
    .ax_ready_o   (s_aw_ready_o),
    .ax_o         (m_aw_o),
    .ax_valid_o   (m_aw_valid_o),
    .ax_ready_i   (m_aw_ready_i),
    .alloc_o      (w_alloc),
    .alloc_len_o  (w_alloc_len),
    .alloc_room_i (w_room)
  );

  beat_tracker w_tracker_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .alloc_i      (w_alloc),
    .alloc_len_i  (w_alloc_len),
    .alloc_room_o (w_room),
    .dec_i        (w_dec),
    .set_err_i    (w_set_err),
    .last_beat_o  (w_last_beat),
    .err_o        (w_err)
  );

  // Data is already single-beat per request, only last changes
  always_comb begin
    m_w_o      = s_w_i;
    m_w_o.last = 1'b1;
  end
  assign m_w_valid_o = s_w_valid_i;
  assign s_w_ready_o = m_w_ready_i;

  b_merge b_merge_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .m_b_i        (m_b_i),
    .m_b_valid_i  (m_b_valid_i),
    .m_b_ready_o  (m_b_ready_o),
    .s_b_o        (s_b_o),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_ready_i  (s_b_ready_i),
    .last_beat_i  (w_last_beat),
    .err_i        (w_err),
    .dec_o        (w_dec),
    .set_err_o    (w_set_err)
  );

  // --------------------------------------------------
  // Read direction
  // --------------------------------------------------
  ax_splitter #(
    .chan_t       (ar_chan_t)
  ) ar_splitter_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .ax_i         (s_ar_i),
    .ax_valid_i   (s_ar_valid_i),
    .ax_ready_o   (s_ar_ready_o),
    .ax_o         (m_ar_o),
    .ax_valid_o   (m_ar_valid_o),
    .ax_ready_i   (m_ar_ready_i),
    .alloc_o      (r_alloc),
    .alloc_len_o  (r_alloc_len),
    .alloc_room_i (r_room)
  );

  // Read errors travel per beat in R, no merging needed
  beat_tracker r_tracker_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .alloc_i      (r_alloc),
    .alloc_len_i  (r_alloc_len),
    .alloc_room_o (r_room),
    .dec_i        (r_dec),
    .set_err_i    (1'b0),
    .last_beat_o  (r_last_beat),
    .err_o        ()
  );

  r_last_gen r_last_gen_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .m_r_i        (m_r_i),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .s_r_o        (s_r_o),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .last_beat_i  (r_last_beat),
    .dec_o        (r_dec)
  );

endmodule

/* hdl/b_merge.sv */
/*
  Merges the B responses of one split write burst into a single B.
  Intermediate responses are absorbed; the final one carries SLVERR
  if any beat of the burst failed. Downstream must answer in order.
*/
`timescale 1ns/1ps

module b_merge (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  burst_split_pkg::b_chan_t m_b_i,
  input  logic                     m_b_valid_i,
  output logic                     m_b_ready_o,
  output burst_split_pkg::b_chan_t s_b_o,
  output logic                     s_b_valid_o,
  input  logic                     s_b_ready_i,
  input  logic                     last_beat_i,
  input  logic                     err_i,
  output logic                     dec_o,
  output logic                     set_err_o
);
  import burst_split_pkg::*;

  typedef enum logic {ST_READY, ST_WAIT} state_e;

  state_e state_d, state_q;
  logic   err_d, err_q;

  always_comb begin
    state_d     = state_q;
    err_d       = err_q;
    m_b_ready_o = 1'b0;
    s_b_o       = m_b_i;
    s_b_valid_o = 1'b0;
    dec_o       = 1'b0;
    set_err_o   = 1'b0;

    case (state_q)
      ST_READY: begin
        if (m_b_valid_i) begin
          dec_o     = 1'b1;
          set_err_o = m_b_i.resp[1];
          if (last_beat_i) begin
            s_b_valid_o = 1'b1;
            if (err_i) begin
              s_b_o.resp = RESP_SLVERR;
            end
            if (s_b_ready_i) begin
              m_b_ready_o = 1'b1;
            end else begin
              // Tracker entry is gone after this edge, keep its error here
              state_d = ST_WAIT;
              err_d   = err_i;
            end
          end else begin
            m_b_ready_o = 1'b1;
          end
        end
      end
      ST_WAIT: begin
        s_b_valid_o = m_b_valid_i;
        if (err_q) begin
          s_b_o.resp = RESP_SLVERR;
        end
        if (m_b_valid_i && s_b_ready_i) begin
          m_b_ready_o = 1'b1;
          state_d     = ST_READY;
        end
      end
      default: state_d = ST_READY;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_READY;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
    end
  end

endmodule

/* hdl/beat_tracker.sv */
/*
  In-order FIFO of outstanding burst lengths, MAX_TXNS deep.
  Responses must come back in request order; only the head entry counts.
  alloc_i must only be raised while alloc_room_o is high.
  The error flag is per entry and sticky until the entry is reused.
*/
`timescale 1ns/1ps

module beat_tracker (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Allocation from the address splitter
  input  logic                  alloc_i,
  input  burst_split_pkg::len_t alloc_len_i,
  output logic                  alloc_room_o,
  // Response side
  input  logic                  dec_i,
  input  logic                  set_err_i,
  output logic                  last_beat_o,
  output logic                  err_o
);
  import burst_split_pkg::*;

  len_t                fifo_q [MAX_TXNS];
  logic [MAX_TXNS-1:0] err_q;
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [FILL_W-1:0]   fill_q;
  // Beats already answered for the head burst
  len_t                head_cnt_q;
  logic                pop;

  assign alloc_room_o = (fill_q != FILL_W'(MAX_TXNS));
  assign last_beat_o  = (head_cnt_q == fifo_q[rd_ptr_q]);
  // Current-cycle error counts too, so the final beat sees its own error
  assign err_o        = err_q[rd_ptr_q] | set_err_i;
  assign pop          = dec_i & last_beat_o;

  // --------------------------------------------------
  // Length storage
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      fifo_q[wr_ptr_q] <= alloc_len_i;
    end
  end

  // --------------------------------------------------
  // Pointers, fill level, head count, errors
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fill_q     <= '0;
      head_cnt_q <= '0;
      err_q      <= '0;
    end else begin
      if (alloc_i) begin
        wr_ptr_q        <= wr_ptr_q + 1'b1;
        err_q[wr_ptr_q] <= 1'b0;
      end
      if (set_err_i) begin
        err_q[rd_ptr_q] <= 1'b1;
      end
      if (dec_i) begin
        if (last_beat_o) begin
          rd_ptr_q   <= rd_ptr_q + 1'b1;
          head_cnt_q <= '0;
        end else begin
          head_cnt_q <= head_cnt_q + 1'b1;
        end
      end
      case ({alloc_i, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

endmodule

/* hdl/burst_split_pkg.sv */
/*
  Shared widths, codes and AXI channel structs for the burst splitter.
  MAX_TXNS must be a power of two, at least 2.
  WRAP bursts are not supported and must not reach the splitter.
*/
package burst_split_pkg;

  // --------------------------------------------------
  // Widths and limits
  // --------------------------------------------------
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned STRB_W   = DATA_W / 8;
  localparam int unsigned ID_W     = 4;
  localparam int unsigned MAX_TXNS = 4;
  localparam int unsigned PTR_W    = $clog2(MAX_TXNS);
  localparam int unsigned FILL_W   = PTR_W + 1;

  // --------------------------------------------------
  // Field types and codes
  // --------------------------------------------------
  typedef logic [7:0]        len_t;
  typedef logic [2:0]        size_t;
  typedef logic [1:0]        burst_t;
  typedef logic [1:0]        resp_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   id_t;

  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // --------------------------------------------------
  // Channel payloads
  // --------------------------------------------------
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } aw_chan_t;

  // Same layout as AW, separate type so the two directions cannot be mixed up
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

endpackage

/* hdl/r_last_gen.sv */
/*
  Forwards read beats upstream and rebuilds last from the tracker.
  The beat count is taken once per beat; under back-pressure the
  computed last flag is held until upstream accepts the beat.
*/
`timescale 1ns/1ps

module r_last_gen (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  burst_split_pkg::r_chan_t m_r_i,
  input  logic                     m_r_valid_i,
  output logic                     m_r_ready_o,
  output burst_split_pkg::r_chan_t s_r_o,
  output logic                     s_r_valid_o,
  input  logic                     s_r_ready_i,
  input  logic                     last_beat_i,
  output logic                     dec_o
);

  typedef enum logic {ST_FEED, ST_WAIT} state_e;

  state_e state_d, state_q;
  logic   last_d, last_q;

  always_comb begin
    state_d     = state_q;
    last_d      = last_q;
    m_r_ready_o = 1'b0;
    s_r_o       = m_r_i;
    s_r_o.last  = last_beat_i;
    s_r_valid_o = 1'b0;
    dec_o       = 1'b0;

    case (state_q)
      ST_FEED: begin
        if (m_r_valid_i) begin
          dec_o       = 1'b1;
          last_d      = last_beat_i;
          s_r_valid_o = 1'b1;
          if (s_r_ready_i) begin
            m_r_ready_o = 1'b1;
          end else begin
            state_d = ST_WAIT;
          end
        end
      end
      ST_WAIT: begin
        // Count already taken, replay the stored last flag
        s_r_o.last  = last_q;
        s_r_valid_o = m_r_valid_i;
        if (m_r_valid_i && s_r_ready_i) begin
          m_r_ready_o = 1'b1;
          state_d     = ST_FEED;
        end
      end
      default: state_d = ST_FEED;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_FEED;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_axi_burst_splitter -f vlog.f || exit 1
out=$(./obj_dir/Vtb_axi_burst_splitter 2>&1)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* vlog.f */
hdl/burst_split_pkg.sv
hdl/ax_splitter.sv
hdl/beat_tracker.sv
hdl/b_merge.sv
hdl/r_last_gen.sv
hdl/axi_burst_splitter.sv
dv/tb_axi_burst_splitter.sv
